// File: logic/afu_defines.svh
`ifndef AFU_DEFINES_SVH
`define AFU_DEFINES_SVH

// Bus widths
`define AFU_LINE_BITS       512
`define AFU_MEM_ADDR_BITS   26
`define AFU_HOST_ADDR_BITS  42
`define AFU_MMIO_ADDR_BITS  16
`define AFU_TID_BITS        9
`define AFU_MDATA_BITS      16

`define AFU_RD_WINDOW       8   // Host reads per window
`define AFU_QUEUE_DEPTH     16
`define AFU_MAX_PEND_WRITES 64

// MMIO map
`define AFU_ID_LO_ADDR      16'h0002
`define AFU_ID_HI_ADDR      16'h0004
`define AFU_CSR_CMD         16'h000A
`define AFU_CSR_IO_ADDR     16'h000C
`define AFU_CSR_MEM_ADDR    16'h000E
`define AFU_CSR_DATA_SIZE   16'h0010
`define AFU_CSR_STATUS      16'h0012

`define AFU_ID_LO           64'h9b4c_1f02_7e3a_d581
`define AFU_ID_HI           64'h35c1_8e0d_a247_6bf3
`define AFU_DFH             64'h1000_0100_0000_0000  // AFU feature, last in list

`define AFU_CMD_READ        3'd1
`define AFU_CMD_WRITE       3'd2

`define AFU_STATE_IDLE      2'd0
`define AFU_STATE_READ      2'd1
`define AFU_STATE_WRITE     2'd2

`endif

// File: logic/ccip_pkg.sv
`default_nettype none

`include "afu_defines.svh"

package ccip_pkg;

  // c0 receive header, MMIO request or host read response
  typedef union packed {
    struct packed {
      logic [`AFU_MMIO_ADDR_BITS-1:0] address;
      logic [1:0]                     length;
      logic                           rsvd;
      logic [`AFU_TID_BITS-1:0]       tid;
    } mmio;
    struct packed {
      logic [11:0]                rsvd;
      logic [`AFU_MDATA_BITS-1:0] mdata;   // Carries the window tag
    } mem;
  } t_c0_rx_hdr;

endpackage

`default_nettype wire

// File: logic/mem_req_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

interface mem_req_if;
  logic                          req_valid;
  logic                          req_write;
  logic [`AFU_MEM_ADDR_BITS-1:0] req_addr;
  logic [`AFU_LINE_BITS-1:0]     req_data;
  logic                          req_ready;
  logic                          rsp_valid;  // Read queue head present
  logic [`AFU_LINE_BITS-1:0]     rsp_data;
  logic                          rsp_pop;

  modport engine (output req_valid, req_write, req_addr, req_data, rsp_pop,
                  input  req_ready, rsp_valid, rsp_data);
  modport port   (input  req_valid, req_write, req_addr, req_data, rsp_pop,
                  output req_ready, rsp_valid, rsp_data);
endinterface

`default_nettype wire

// File: logic/line_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module line_fifo #(
  parameter int WIDTH = 512,
  parameter int DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             push,
  input  logic [WIDTH-1:0] din,
  input  logic             pop,
  output logic [WIDTH-1:0] dout,
  output logic             empty,
  output logic             full
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW:0]      wr_ptr;   // Extra bit tells full from empty
  logic [AW:0]      rd_ptr;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign dout  = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (push && !full) begin
      mem[wr_ptr[AW-1:0]] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop && !empty) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/afu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module afu_ctrl import ccip_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           mmio_wr_valid,
  input  logic                           mmio_rd_valid,
  input  t_c0_rx_hdr                     c0_rx_hdr,
  input  logic [`AFU_LINE_BITS-1:0]      c0_rx_data,
  output logic                           mmio_rsp_valid,
  output logic [`AFU_TID_BITS-1:0]       mmio_rsp_tid,
  output logic [63:0]                    mmio_rsp_data,
  output logic [`AFU_HOST_ADDR_BITS-1:0] io_addr,
  output logic [`AFU_MEM_ADDR_BITS-1:0]  mem_addr,
  output logic [`AFU_MEM_ADDR_BITS-1:0]  data_size,
  output logic                           start_read,
  output logic                           start_write,
  input  logic                           read_done,
  input  logic                           write_done
);

  logic [1:0]                     state;
  logic [2:0]                     cmd;
  logic [2:0]                     wr_cmd;
  logic [`AFU_MMIO_ADDR_BITS-1:0] addr;

  assign addr   = c0_rx_hdr.mmio.address;
  assign wr_cmd = c0_rx_data[2:0];

  assign start_read  = (state == `AFU_STATE_IDLE) && (cmd == `AFU_CMD_READ);
  assign start_write = (state == `AFU_STATE_IDLE) && (cmd == `AFU_CMD_WRITE);

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd       <= '0;
      io_addr   <= '0;
      mem_addr  <= '0;
      data_size <= '0;
    end else begin
      cmd <= '0;   // One-cycle command pulse
      if (mmio_wr_valid) begin
        case (addr)
          `AFU_CSR_IO_ADDR:   io_addr   <= c0_rx_data[`AFU_HOST_ADDR_BITS-1:0];
          `AFU_CSR_MEM_ADDR:  mem_addr  <= c0_rx_data[`AFU_MEM_ADDR_BITS-1:0];
          `AFU_CSR_DATA_SIZE: data_size <= c0_rx_data[`AFU_MEM_ADDR_BITS-1:0];
          `AFU_CSR_CMD: begin
            if ((wr_cmd == `AFU_CMD_READ) || (wr_cmd == `AFU_CMD_WRITE)) begin
              cmd <= wr_cmd;
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Command FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= `AFU_STATE_IDLE;
    end else begin
      case (state)
        `AFU_STATE_IDLE: begin
          if (start_read) begin
            state <= `AFU_STATE_READ;
          end else if (start_write) begin
            state <= `AFU_STATE_WRITE;
          end
        end
        `AFU_STATE_READ: begin
          if (read_done) begin
            state <= `AFU_STATE_IDLE;
          end
        end
        `AFU_STATE_WRITE: begin
          if (write_done) begin
            state <= `AFU_STATE_IDLE;
          end
        end
        default: state <= `AFU_STATE_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mmio_rsp_valid <= 1'b0;
    end else begin
      mmio_rsp_valid <= mmio_rd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mmio_rd_valid) begin
      mmio_rsp_tid <= c0_rx_hdr.mmio.tid;
      case (addr)
        16'h0000:        mmio_rsp_data <= `AFU_DFH;
        `AFU_ID_LO_ADDR: mmio_rsp_data <= `AFU_ID_LO;
        `AFU_ID_HI_ADDR: mmio_rsp_data <= `AFU_ID_HI;
        `AFU_CSR_STATUS: mmio_rsp_data <= 64'(state);
        default:         mmio_rsp_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/local_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module local_mem_port (
  input  logic                          clk,
  input  logic                          rst,
  mem_req_if.port                       rd,
  mem_req_if.port                       wr,
  output logic [`AFU_MEM_ADDR_BITS-1:0] avs_address,
  output logic                          avs_read,
  output logic                          avs_write,
  output logic [`AFU_LINE_BITS-1:0]     avs_writedata,
  input  logic [`AFU_LINE_BITS-1:0]     avs_readdata,
  input  logic                          avs_readdatavalid,
  input  logic                          avs_waitrequest
);

  localparam int PW = $clog2(`AFU_QUEUE_DEPTH + 1);

  logic                      use_wr;
  logic                      rd_room;
  logic                      rd_fire;
  logic                      q_pop;
  logic                      q_empty;
  logic [`AFU_LINE_BITS-1:0] q_dout;
  logic [PW-1:0]             pending;   // Reads issued, not yet popped

  // Only one engine runs at a time
  assign use_wr  = wr.req_valid;
  assign rd_room = (pending < PW'(`AFU_QUEUE_DEPTH));

  always_comb begin
    if (use_wr) begin
      avs_address   = wr.req_addr;
      avs_writedata = wr.req_data;
      avs_write     = wr.req_write;
      avs_read      = !wr.req_write && rd_room;
    end else begin
      avs_address   = rd.req_addr;
      avs_writedata = rd.req_data;
      avs_write     = rd.req_valid && rd.req_write;
      avs_read      = rd.req_valid && !rd.req_write && rd_room;
    end
  end

  assign wr.req_ready = use_wr && !avs_waitrequest && (wr.req_write || rd_room);
  assign rd.req_ready = !use_wr && !avs_waitrequest && (rd.req_write || rd_room);

  assign rd_fire = avs_read && !avs_waitrequest;
  assign q_pop   = (rd.rsp_pop || wr.rsp_pop) && !q_empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= pending + PW'(rd_fire) - PW'(q_pop);
    end
  end

  line_fifo #(
    .WIDTH (`AFU_LINE_BITS),
    .DEPTH (`AFU_QUEUE_DEPTH)
  ) i_rd_queue (
    .clk   (clk),
    .rst   (rst),
    .push  (avs_readdatavalid),
    .din   (avs_readdata),
    .pop   (q_pop),
    .dout  (q_dout),
    .empty (q_empty),
    .full  ()   // Pending limit keeps it from filling
  );

  assign rd.rsp_valid = !q_empty;
  assign rd.rsp_data  = q_dout;
  assign wr.rsp_valid = !q_empty;
  assign wr.rsp_data  = q_dout;

endmodule

`default_nettype wire

// File: logic/dram_to_host.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module dram_to_host (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [`AFU_MEM_ADDR_BITS-1:0]  mem_addr,
  input  logic [`AFU_HOST_ADDR_BITS-1:0] io_addr,
  input  logic [`AFU_MEM_ADDR_BITS-1:0]  data_size,
  output logic                           done,
  mem_req_if.engine                      mem,
  output logic                           c1_req_valid,
  output logic [`AFU_HOST_ADDR_BITS-1:0] c1_req_addr,
  output logic [`AFU_LINE_BITS-1:0]      c1_req_data,
  input  logic                           c1_tx_alm_full,
  input  logic                           c1_rsp_valid
);

  localparam int PW = $clog2(`AFU_MAX_PEND_WRITES + 1);

  logic                           busy;
  logic [`AFU_MEM_ADDR_BITS-1:0]  rd_addr;
  logic [`AFU_MEM_ADDR_BITS-1:0]  rd_left;
  logic [`AFU_MEM_ADDR_BITS-1:0]  wr_left;
  logic [`AFU_HOST_ADDR_BITS-1:0] wr_addr;
  logic [PW-1:0]                  pend;   // Unacked host writes
  logic                           rd_fire;
  logic                           wr_fire;
  logic                           ack;

  assign mem.req_valid = busy && (rd_left != '0);
  assign mem.req_write = 1'b0;
  assign mem.req_addr  = rd_addr;
  assign mem.req_data  = '0;
  assign rd_fire       = mem.req_valid && mem.req_ready;

  // Queue head goes straight out on c1
  assign c1_req_valid = busy && mem.rsp_valid && (pend < PW'(`AFU_MAX_PEND_WRITES));
  assign c1_req_addr  = wr_addr;
  assign c1_req_data  = mem.rsp_data;
  assign wr_fire      = c1_req_valid && !c1_tx_alm_full;
  assign mem.rsp_pop  = wr_fire;
  assign ack          = busy && c1_rsp_valid;

  assign done = busy && (wr_left == '0) && (pend == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      rd_addr <= '0;
      rd_left <= '0;
      wr_addr <= '0;
      wr_left <= '0;
      pend    <= '0;
    end else if (!busy) begin
      if (start) begin
        busy    <= 1'b1;
        rd_addr <= mem_addr;
        rd_left <= data_size;
        wr_addr <= io_addr;
        wr_left <= data_size;
        pend    <= '0;
      end
    end else begin
      if (done) begin
        busy <= 1'b0;
      end
      if (rd_fire) begin
        rd_addr <= rd_addr + 1'b1;
        rd_left <= rd_left - 1'b1;
      end
      if (wr_fire) begin
        wr_addr <= wr_addr + 1'b1;
        wr_left <= wr_left - 1'b1;
      end
      pend <= pend + PW'(wr_fire) - PW'(ack);
    end
  end

endmodule

`default_nettype wire

// File: logic/host_to_dram.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module host_to_dram import ccip_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           start,
  input  logic [`AFU_HOST_ADDR_BITS-1:0] io_addr,
  input  logic [`AFU_MEM_ADDR_BITS-1:0]  mem_addr,
  input  logic [`AFU_MEM_ADDR_BITS-1:0]  data_size,
  output logic                           done,
  output logic                           c0_req_valid,
  output logic [`AFU_HOST_ADDR_BITS-1:0] c0_req_addr,
  output logic [`AFU_MDATA_BITS-1:0]     c0_req_mdata,
  input  logic                           c0_tx_alm_full,
  input  logic                           c0_rsp_valid,
  input  t_c0_rx_hdr                     c0_rx_hdr,
  input  logic [`AFU_LINE_BITS-1:0]      c0_rx_data,
  mem_req_if.engine                      mem
);

  localparam int TW = $clog2(`AFU_RD_WINDOW);
  localparam int QW = $clog2(`AFU_QUEUE_DEPTH + 1);

  logic                           busy;
  logic                           win_wait;   // Window issued, responses due
  logic [`AFU_HOST_ADDR_BITS-1:0] req_addr;
  logic [`AFU_MEM_ADDR_BITS-1:0]  req_left;
  logic [`AFU_MEM_ADDR_BITS-1:0]  wr_left;
  logic [`AFU_MEM_ADDR_BITS-1:0]  win_base;
  logic [TW-1:0]                  req_tag;
  logic [TW-1:0]                  rsp_cnt;
  logic [TW-1:0]                  wr_idx;
  logic [QW-1:0]                  q_cnt;      // Requested, not yet written
  logic                           req_fire;
  logic                           rsp_fire;
  logic                           q_pop;
  logic                           q_empty;
  logic [`AFU_LINE_BITS+TW-1:0]   q_dout;

  assign c0_req_valid = busy && (req_left != '0) && !win_wait
                        && (q_cnt < QW'(`AFU_QUEUE_DEPTH));
  assign c0_req_addr  = req_addr;
  assign c0_req_mdata = `AFU_MDATA_BITS'(req_tag);
  assign req_fire     = c0_req_valid && !c0_tx_alm_full;
  assign rsp_fire     = busy && c0_rsp_valid;

  line_fifo #(
    .WIDTH (`AFU_LINE_BITS + TW),
    .DEPTH (`AFU_QUEUE_DEPTH)
  ) i_rsp_queue (
    .clk   (clk),
    .rst   (rst),
    .push  (rsp_fire),
    .din   ({c0_rx_data, c0_rx_hdr.mem.mdata[TW-1:0]}),
    .pop   (q_pop),
    .dout  (q_dout),
    .empty (q_empty),
    .full  ()
  );

  // Out-of-order line lands at window base plus its tag
  assign mem.req_valid = busy && !q_empty;
  assign mem.req_write = 1'b1;
  assign mem.req_addr  = win_base + `AFU_MEM_ADDR_BITS'(q_dout[TW-1:0]);
  assign mem.req_data  = q_dout[`AFU_LINE_BITS+TW-1:TW];
  assign mem.rsp_pop   = 1'b0;
  assign q_pop         = mem.req_valid && mem.req_ready;

  assign done = busy && (wr_left == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      win_wait <= 1'b0;
      req_addr <= '0;
      req_left <= '0;
      wr_left  <= '0;
      win_base <= '0;
      req_tag  <= '0;
      rsp_cnt  <= '0;
      wr_idx   <= '0;
      q_cnt    <= '0;
    end else if (!busy) begin
      if (start) begin
        busy     <= 1'b1;
        win_wait <= 1'b0;
        req_addr <= io_addr;
        req_left <= data_size;
        wr_left  <= data_size;
        win_base <= mem_addr;
        req_tag  <= '0;
        rsp_cnt  <= '0;
        wr_idx   <= '0;
        q_cnt    <= '0;
      end
    end else begin
      if (done) begin
        busy <= 1'b0;
      end
      if (req_fire) begin
        req_addr <= req_addr + 1'b1;
        req_left <= req_left - 1'b1;
        req_tag  <= req_tag + 1'b1;
        if (req_tag == TW'(`AFU_RD_WINDOW - 1)) begin
          win_wait <= 1'b1;
        end
      end
      if (rsp_fire) begin
        rsp_cnt <= rsp_cnt + 1'b1;
        if (rsp_cnt == TW'(`AFU_RD_WINDOW - 1)) begin
          win_wait <= 1'b0;   // Whole window back
        end
      end
      if (q_pop) begin
        wr_left <= wr_left - 1'b1;
        wr_idx  <= wr_idx + 1'b1;
        if (wr_idx == TW'(`AFU_RD_WINDOW - 1)) begin
          win_base <= win_base + `AFU_MEM_ADDR_BITS'(`AFU_RD_WINDOW);
        end
      end
      q_cnt <= q_cnt + QW'(req_fire) - QW'(q_pop);
    end
  end

endmodule

`default_nettype wire

// File: logic/copy_afu.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module copy_afu import ccip_pkg::*; (
  input  logic                           clk,
  input  logic                           rst,
  // Host side
  input  t_c0_rx_hdr                     c0_rx_hdr,
  input  logic [`AFU_LINE_BITS-1:0]      c0_rx_data,
  input  logic                           mmio_wr_valid,
  input  logic                           mmio_rd_valid,
  input  logic                           c0_rsp_valid,
  input  logic                           c1_rsp_valid,
  input  logic                           c0_tx_alm_full,
  input  logic                           c1_tx_alm_full,
  output logic                           mmio_rsp_valid,
  output logic [`AFU_TID_BITS-1:0]       mmio_rsp_tid,
  output logic [63:0]                    mmio_rsp_data,
  output logic                           c0_req_valid,
  output logic [`AFU_HOST_ADDR_BITS-1:0] c0_req_addr,
  output logic [`AFU_MDATA_BITS-1:0]     c0_req_mdata,
  output logic                           c1_req_valid,
  output logic [`AFU_HOST_ADDR_BITS-1:0] c1_req_addr,
  output logic [`AFU_LINE_BITS-1:0]      c1_req_data,
  // Local memory
  output logic [`AFU_MEM_ADDR_BITS-1:0]  avs_address,
  output logic                           avs_read,
  output logic                           avs_write,
  output logic [`AFU_LINE_BITS-1:0]      avs_writedata,
  input  logic [`AFU_LINE_BITS-1:0]      avs_readdata,
  input  logic                           avs_readdatavalid,
  input  logic                           avs_waitrequest
);

  logic [`AFU_HOST_ADDR_BITS-1:0] io_addr;
  logic [`AFU_MEM_ADDR_BITS-1:0]  mem_addr;
  logic [`AFU_MEM_ADDR_BITS-1:0]  data_size;
  logic                           start_read;
  logic                           start_write;
  logic                           read_done;
  logic                           write_done;

  mem_req_if rd_if ();
  mem_req_if wr_if ();

  afu_ctrl i_ctrl (
    .clk            (clk),
    .rst            (rst),
    .mmio_wr_valid  (mmio_wr_valid),
    .mmio_rd_valid  (mmio_rd_valid),
    .c0_rx_hdr      (c0_rx_hdr),
    .c0_rx_data     (c0_rx_data),
    .mmio_rsp_valid (mmio_rsp_valid),
    .mmio_rsp_tid   (mmio_rsp_tid),
    .mmio_rsp_data  (mmio_rsp_data),
    .io_addr        (io_addr),
    .mem_addr       (mem_addr),
    .data_size      (data_size),
    .start_read     (start_read),
    .start_write    (start_write),
    .read_done      (read_done),
    .write_done     (write_done)
  );

  local_mem_port i_mem_port (
    .clk               (clk),
    .rst               (rst),
    .rd                (rd_if.port),
    .wr                (wr_if.port),
    .avs_address       (avs_address),
    .avs_read          (avs_read),
    .avs_write         (avs_write),
    .avs_writedata     (avs_writedata),
    .avs_readdata      (avs_readdata),
    .avs_readdatavalid (avs_readdatavalid),
    .avs_waitrequest   (avs_waitrequest)
  );

  // READ command, local memory to host
  dram_to_host i_d2h (
    .clk            (clk),
    .rst            (rst),
    .start          (start_read),
    .mem_addr       (mem_addr),
    .io_addr        (io_addr),
    .data_size      (data_size),
    .done           (read_done),
    .mem            (rd_if.engine),
    .c1_req_valid   (c1_req_valid),
    .c1_req_addr    (c1_req_addr),
    .c1_req_data    (c1_req_data),
    .c1_tx_alm_full (c1_tx_alm_full),
    .c1_rsp_valid   (c1_rsp_valid)
  );

  // WRITE command, host to local memory
  host_to_dram i_h2d (
    .clk            (clk),
    .rst            (rst),
    .start          (start_write),
    .io_addr        (io_addr),
    .mem_addr       (mem_addr),
    .data_size      (data_size),
    .done           (write_done),
    .c0_req_valid   (c0_req_valid),
    .c0_req_addr    (c0_req_addr),
    .c0_req_mdata   (c0_req_mdata),
    .c0_tx_alm_full (c0_tx_alm_full),
    .c0_rsp_valid   (c0_rsp_valid),
    .c0_rx_hdr      (c0_rx_hdr),
    .c0_rx_data     (c0_rx_data),
    .mem            (wr_if.engine)
  );

endmodule

`default_nettype wire

// File: tb/copy_afu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module copy_afu_assertions (
  input logic                          clk,
  input logic                          rst,
  input logic                          avs_read,
  input logic                          avs_write,
  input logic [`AFU_MEM_ADDR_BITS-1:0] avs_address,
  input logic [`AFU_LINE_BITS-1:0]     avs_writedata,
  input logic                          avs_waitrequest,
  input logic                          mmio_rd_valid,
  input logic                          mmio_rsp_valid
);

  int unsigned failures = 0;   // Watched by the testbench

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(avs_read && avs_write))
    else begin
      failures++;
      $error("avs_read and avs_write asserted together");
    end

  // Stalled request must not change
  a_avs_hold: assert property (@(posedge clk) disable iff (rst)
    (avs_read || avs_write) && avs_waitrequest |=>
      $stable(avs_read) && $stable(avs_write) && $stable(avs_address)
      && $stable(avs_writedata))
    else begin
      failures++;
      $error("Avalon request changed under waitrequest");
    end

  a_mmio_rsp: assert property (@(posedge clk) disable iff (rst)
    mmio_rd_valid |=> mmio_rsp_valid)
    else begin
      failures++;
      $error("mmio_rsp_valid missing one cycle after mmio_rd_valid");
    end

  a_mmio_no_extra: assert property (@(posedge clk) disable iff (rst)
    mmio_rsp_valid |-> $past(mmio_rd_valid))
    else begin
      failures++;
      $error("mmio_rsp_valid without a read one cycle earlier");
    end

endmodule

`default_nettype wire

// File: tb/copy_afu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module copy_afu_tb import ccip_pkg::*; ();

  typedef struct packed {
    logic [2:0]  cmd;
    logic [41:0] io;
    logic [25:0] mem;
    logic [25:0] size;
    logic [1:0]  state;    // Status expected while running
    logic [6:0]  stress;   // Back-pressure percentage
  } entry_t;

  localparam int NUM_CMDS    = 9;
  localparam int CYCLE_LIMIT = 2000 + 200 * NUM_CMDS;

  logic                           clk = 1'b0;
  logic                           rst = 1'b1;
  t_c0_rx_hdr                     c0_rx_hdr = '0;
  logic [`AFU_LINE_BITS-1:0]      c0_rx_data = '0;
  logic                           mmio_wr_valid = 1'b0;
  logic                           mmio_rd_valid = 1'b0;
  logic                           c0_rsp_valid = 1'b0;
  logic                           c1_rsp_valid = 1'b0;
  logic                           c0_tx_alm_full = 1'b0;
  logic                           c1_tx_alm_full = 1'b0;
  logic [`AFU_LINE_BITS-1:0]      avs_readdata = '0;
  logic                           avs_readdatavalid = 1'b0;
  logic                           avs_waitrequest = 1'b0;
  logic                           mmio_rsp_valid;
  logic [`AFU_TID_BITS-1:0]       mmio_rsp_tid;
  logic [63:0]                    mmio_rsp_data;
  logic                           c0_req_valid;
  logic [`AFU_HOST_ADDR_BITS-1:0] c0_req_addr;
  logic [`AFU_MDATA_BITS-1:0]     c0_req_mdata;
  logic                           c1_req_valid;
  logic [`AFU_HOST_ADDR_BITS-1:0] c1_req_addr;
  logic [`AFU_LINE_BITS-1:0]      c1_req_data;
  logic [`AFU_MEM_ADDR_BITS-1:0]  avs_address;
  logic                           avs_read;
  logic                           avs_write;
  logic [`AFU_LINE_BITS-1:0]      avs_writedata;

  // Memory models, indexed by line address
  logic [511:0] host_mem [logic [41:0]];
  logic [511:0] dram [logic [25:0]];
  logic [41:0]  c0_pend_addr [$];
  logic [15:0]  c0_pend_tag [$];
  logic [511:0] rd_return [$];

  entry_t       cmds [NUM_CMDS];
  int           stress_pct = 20;
  int           n_c0 = 0;
  int           n_c1 = 0;
  int           n_avs = 0;
  int           acks_owed = 0;
  int           cycles = 0;
  logic         mmio_pend = 1'b0;   // MMIO request waiting for the c0 driver
  logic         mmio_is_wr = 1'b0;
  logic [15:0]  mmio_addr = '0;
  logic [63:0]  mmio_wdata = '0;
  logic [8:0]   mmio_tid = '0;

  copy_afu i_dut (.*);

  bind copy_afu copy_afu_assertions i_assertions (
    .clk             (clk),
    .rst             (rst),
    .avs_read        (avs_read),
    .avs_write       (avs_write),
    .avs_address     (avs_address),
    .avs_writedata   (avs_writedata),
    .avs_waitrequest (avs_waitrequest),
    .mmio_rd_valid   (mmio_rd_valid),
    .mmio_rsp_valid  (mmio_rsp_valid)
  );

  always #5 clk = ~clk;

  function automatic bit chance(input int pct);
    return $urandom_range(99) < pct;
  endfunction

  // Unwritten lines hold a pattern of the full address
  function automatic logic [511:0] fill_line(input logic [7:0] mem_id, input logic [63:0] addr);
    logic [511:0] line;
    int k;
    for (k = 0; k < 8; k++) begin
      line[64*k +: 64] = {mem_id, addr[55:0]} ^ (64'h9e37_79b9_7f4a_7c15 * 64'(k + 1));
    end
    return line;
  endfunction

  function automatic logic [511:0] host_read(input logic [41:0] addr);
    return host_mem.exists(addr) ? host_mem[addr] : fill_line(8'h48, 64'(addr));
  endfunction

  function automatic logic [511:0] dram_read(input logic [25:0] addr);
    return dram.exists(addr) ? dram[addr] : fill_line(8'hd4, 64'(addr));
  endfunction

  task automatic check_value(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
    if (got !== exp) begin
      $display("error: %s is %0h, expected %0h", name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic mmio_write(input logic [15:0] addr, input logic [63:0] data);
    @(negedge clk);
    mmio_addr  = addr;
    mmio_wdata = data;
    mmio_is_wr = 1'b1;
    mmio_pend  = 1'b1;
    @(negedge clk);
  endtask

  task automatic mmio_read(input logic [15:0] addr, output logic [63:0] data);
    @(negedge clk);
    mmio_tid   = mmio_tid + 1'b1;
    mmio_addr  = addr;
    mmio_is_wr = 1'b0;
    mmio_pend  = 1'b1;
    repeat (2) @(negedge clk);   // Request cycle, then response cycle
    check_value("mmio_rsp_valid", mmio_rsp_valid, 1'b1);
    check_value("mmio_rsp_tid", mmio_rsp_tid, mmio_tid);
    data = mmio_rsp_data;
  endtask

  // c0 receive side, MMIO first, then host read responses
  always @(posedge clk) begin : host_c0
    t_c0_rx_hdr hdr;
    int idx;
    hdr = '0;
    mmio_wr_valid <= 1'b0;
    mmio_rd_valid <= 1'b0;
    c0_rsp_valid  <= 1'b0;
    if (c0_req_valid && !c0_tx_alm_full) begin
      c0_pend_addr.push_back(c0_req_addr);
      c0_pend_tag.push_back(c0_req_mdata);
      n_c0++;
    end
    if (mmio_pend) begin
      hdr.mmio.address = mmio_addr;
      hdr.mmio.length  = 2'b01;
      hdr.mmio.tid     = mmio_tid;
      c0_rx_hdr     <= hdr;
      c0_rx_data    <= 512'(mmio_wdata);
      mmio_wr_valid <= mmio_is_wr;
      mmio_rd_valid <= !mmio_is_wr;
      mmio_pend = 1'b0;
    end else if (c0_pend_addr.size() != 0 && (c0_pend_addr.size() == 8 || !c0_req_valid)
                 && chance(60)) begin
      idx = $urandom_range(c0_pend_addr.size() - 1);   // Any order inside the window
      hdr.mem.mdata = c0_pend_tag[idx];
      c0_rx_hdr    <= hdr;
      c0_rx_data   <= host_read(c0_pend_addr[idx]);
      c0_rsp_valid <= 1'b1;
      c0_pend_addr.delete(idx);
      c0_pend_tag.delete(idx);
    end
    c0_tx_alm_full <= chance(stress_pct);
  end

  always @(posedge clk) begin : host_c1
    c1_rsp_valid <= 1'b0;
    if (c1_req_valid && !c1_tx_alm_full) begin
      host_mem[c1_req_addr] = c1_req_data;
      acks_owed++;
      n_c1++;
    end
    if (acks_owed > 0 && chance(40)) begin
      c1_rsp_valid <= 1'b1;
      acks_owed--;
    end
    c1_tx_alm_full <= chance(stress_pct);
  end

  // Local memory, reads return in order
  always @(posedge clk) begin : local_mem
    avs_readdatavalid <= 1'b0;
    if ((avs_read || avs_write) && !avs_waitrequest) begin
      n_avs++;
      if (avs_write) begin
        dram[avs_address] = avs_writedata;
      end else begin
        rd_return.push_back(dram_read(avs_address));
      end
    end
    if (rd_return.size() != 0 && chance(50)) begin
      avs_readdata      <= rd_return.pop_front();
      avs_readdatavalid <= 1'b1;
    end
    avs_waitrequest <= chance(stress_pct);
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (i_dut.i_assertions.failures != 0) begin
      $display("error: an assertion on the DUT ports failed");
      $display("Test failed");
      $fatal(1, "assertion failure");
    end else if (cycles >= CYCLE_LIMIT) begin
      $display("error: commands did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    logic [63:0] rdata;
    logic        saw_run;
    int          c0_base;
    int          c1_base;
    int          avs_base;
    int          i;
    int          j;
    rdata = $urandom(6027);
    cmds[0] = '{`AFU_CMD_WRITE, 42'h1000, 26'h100, 26'd8, `AFU_STATE_WRITE, 7'd20};
    cmds[1] = '{`AFU_CMD_WRITE, 42'h2003, 26'h205, 26'd13, `AFU_STATE_WRITE, 7'd20};
    cmds[2] = '{`AFU_CMD_READ, 42'h3000, 26'h100, 26'd8, `AFU_STATE_READ, 7'd20};
    cmds[3] = '{`AFU_CMD_READ, 42'h4001, 26'h400, 26'd21, `AFU_STATE_READ, 7'd20};
    cmds[4] = '{`AFU_CMD_WRITE, 42'h5000, 26'h600, 26'd0, `AFU_STATE_WRITE, 7'd20};
    cmds[5] = '{`AFU_CMD_READ, 42'h5100, 26'h700, 26'd0, `AFU_STATE_READ, 7'd20};
    cmds[6] = '{3'd5, 42'h5200, 26'h800, 26'd4, `AFU_STATE_IDLE, 7'd20};
    cmds[7] = '{`AFU_CMD_WRITE, 42'h6000, 26'h1000, 26'd40, `AFU_STATE_WRITE, 7'd60};
    cmds[8] = '{`AFU_CMD_READ, 42'h7005, 26'h2003, 26'd40, `AFU_STATE_READ, 7'd60};

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_value("mmio_rsp_valid", mmio_rsp_valid, 1'b0);
    check_value("c0_req_valid", c0_req_valid, 1'b0);
    check_value("c1_req_valid", c1_req_valid, 1'b0);
    check_value("avs_read", avs_read, 1'b0);
    check_value("avs_write", avs_write, 1'b0);

    mmio_read(16'h0000, rdata);
    check_value("mmio_rsp_data", rdata, `AFU_DFH);
    mmio_read(`AFU_ID_LO_ADDR, rdata);
    check_value("mmio_rsp_data", rdata, `AFU_ID_LO);
    mmio_read(`AFU_ID_HI_ADDR, rdata);
    check_value("mmio_rsp_data", rdata, `AFU_ID_HI);
    mmio_read(16'h0040, rdata);   // Unmapped
    check_value("mmio_rsp_data", rdata, 64'h0);
    mmio_read(`AFU_CSR_STATUS, rdata);
    check_value("mmio_rsp_data", rdata, `AFU_STATE_IDLE);

    for (i = 0; i < NUM_CMDS; i++) begin
      stress_pct = cmds[i].stress;
      c0_base    = n_c0;
      c1_base    = n_c1;
      avs_base   = n_avs;
      mmio_write(`AFU_CSR_IO_ADDR, 64'(cmds[i].io));
      mmio_write(`AFU_CSR_MEM_ADDR, 64'(cmds[i].mem));
      mmio_write(`AFU_CSR_DATA_SIZE, 64'(cmds[i].size));
      mmio_write(`AFU_CSR_CMD, 64'(cmds[i].cmd));
      repeat (2) @(negedge clk);   // Command pulse, then state update
      saw_run = 1'b0;
      do begin
        mmio_read(`AFU_CSR_STATUS, rdata);
        if (rdata != 64'h0) begin
          check_value("mmio_rsp_data", rdata, cmds[i].state);
          saw_run = 1'b1;
        end
      end while (rdata != 64'h0);
      if (cmds[i].size >= 26'd32) begin
        check_value("status running seen", saw_run, 1'b1);
      end

      check_value("c0 request count", n_c0 - c0_base,
                  (cmds[i].state == `AFU_STATE_WRITE) ? cmds[i].size : 0);
      check_value("c1 request count", n_c1 - c1_base,
                  (cmds[i].state == `AFU_STATE_READ) ? cmds[i].size : 0);
      check_value("Avalon request count", n_avs - avs_base,
                  (cmds[i].state == `AFU_STATE_IDLE) ? 0 : cmds[i].size);
      for (j = 0; j < cmds[i].size; j++) begin
        if (cmds[i].state == `AFU_STATE_WRITE) begin
          check_value("avs_writedata", dram_read(cmds[i].mem + 26'(j)),
                      host_read(cmds[i].io + 42'(j)));
        end else if (cmds[i].state == `AFU_STATE_READ) begin
          check_value("c1_req_data", host_read(cmds[i].io + 42'(j)),
                      dram_read(cmds[i].mem + 26'(j)));
        end
      end
    end

    repeat (2) @(negedge clk);
    if (i_dut.i_assertions.failures != 0) begin
      $display("Test failed");
      $fatal(1, "assertion failure");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+logic
logic/ccip_pkg.sv
logic/mem_req_if.sv
logic/line_fifo.sv
logic/afu_ctrl.sv
logic/local_mem_port.sv
logic/dram_to_host.sv
logic/host_to_dram.sv
logic/copy_afu.sv
tb/copy_afu_assertions.sv
tb/copy_afu_tb.sv

// File: Bender.yml
package:
  name: copy_afu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/ccip_pkg.sv
      - logic/mem_req_if.sv
      - logic/line_fifo.sv
      - logic/afu_ctrl.sv
      - logic/local_mem_port.sv
      - logic/dram_to_host.sv
      - logic/host_to_dram.sv
      - logic/copy_afu.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/copy_afu_assertions.sv
      - tb/copy_afu_tb.sv
